//--- filelist.f
+incdir+common
common/axi_lite_pkg.sv
common/rtx_scene_pkg.sv
verilog/ray_caster.sv
verilog/hit_test.sv
scene/scene_buffer.sv
verilog/ray_control.sv
verilog/rtx_top.sv
verif/tb_rtx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the renderer testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rtx -f filelist.f -o sim_rtx

./obj_dir/sim_rtx | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- verif/tb_rtx.sv
`timescale 1ns/1ps
`include "rtx_params.svh"

module tb_rtx;

  localparam int W           = `RTX_WIDTH;
  localparam int H           = `RTX_HEIGHT;
  localparam int DEPTH       = `RTX_SCENE_DEPTH;
  localparam int NUM_FRAMES  = 5;
  localparam int CYCLE_LIMIT = NUM_FRAMES * (W * H * (DEPTH + 3)) + 500;

  logic                      clk;
  logic                      rst_n;
  logic                      start;
  axi_lite_pkg::axi_addr_t   awaddr;
  logic                      awvalid;
  axi_lite_pkg::axi_data_t   wdata;
  logic [3:0]                wstrb;
  logic                      wvalid;
  logic                      bready;
  logic                      awready;
  logic                      wready;
  axi_lite_pkg::axi_resp_e   bresp;
  logic                      bvalid;
  logic [15:0]               rtx_pixel;
  rtx_scene_pkg::coord_t     pixel_h;
  rtx_scene_pkg::coord_t     pixel_v;
  logic                      ray_done;
  logic                      frame_done;

  // Scene copy for the reference model
  rtx_scene_pkg::scene_obj_u model_obj [DEPTH];
  int                        model_count;

  // Write table: address, data, expected response
  axi_lite_pkg::axi_addr_t   tbl_addr [$];
  axi_lite_pkg::axi_data_t   tbl_data [$];
  axi_lite_pkg::axi_resp_e   tbl_resp [$];

  int value_errs;
  int proto_errs;
  int cycles;
  int seed;

  rtx_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .bready    (bready),
    .awready   (awready),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .rtx_pixel (rtx_pixel),
    .pixel_h   (pixel_h),
    .pixel_v   (pixel_v),
    .ray_done  (ray_done),
    .frame_done(frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, got);
      value_errs++;
    end
  endtask

  task automatic axi_write(input axi_lite_pkg::axi_addr_t addr,
                           input axi_lite_pkg::axi_data_t data,
                           input axi_lite_pkg::axi_resp_e exp_resp);
    string name;
    name = $sformatf("write %03h", addr);
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Response must wait while bready stays low
    repeat (2) begin
      @(negedge clk);
      assert (bvalid) else begin
        $display("bvalid went low while bready was held low on %s", name);
        proto_errs++;
      end
    end
    check_value({name, " bresp"}, 32'(exp_resp), 32'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic queue_write(input int addr, input logic [31:0] data,
                             input axi_lite_pkg::axi_resp_e resp);
    tbl_addr.push_back(axi_lite_pkg::axi_addr_t'(addr));
    tbl_data.push_back(data);
    tbl_resp.push_back(resp);
  endtask

  task automatic queue_object(input int idx, input rtx_scene_pkg::scene_obj_u o);
    model_obj[idx] = o;
    queue_write(8 * idx, o[31:0], axi_lite_pkg::RESP_OKAY);
    queue_write(8 * idx + 4, o[63:32], axi_lite_pkg::RESP_OKAY);
  endtask

  task automatic queue_count(input int n);
    if (n <= DEPTH) begin
      model_count = n;
      queue_write(`RTX_COUNT_ADDR, n, axi_lite_pkg::RESP_OKAY);
    end else begin
      queue_write(`RTX_COUNT_ADDR, n, axi_lite_pkg::RESP_SLVERR);
    end
  endtask

  task automatic run_writes;
    while (tbl_addr.size() > 0) begin
      axi_write(tbl_addr.pop_front(), tbl_data.pop_front(), tbl_resp.pop_front());
    end
  endtask

  function automatic rtx_scene_pkg::scene_obj_u make_sphere(
      input rtx_scene_pkg::coord_t cx, input rtx_scene_pkg::coord_t cy,
      input rtx_scene_pkg::coord_t r, input rtx_scene_pkg::coord_t depth,
      input logic [15:0] color);
    rtx_scene_pkg::scene_obj_u o;
    o               = '0;
    o.sphere.kind   = rtx_scene_pkg::OBJ_SPHERE;
    o.sphere.cx     = cx;
    o.sphere.cy     = cy;
    o.sphere.radius = r;
    o.sphere.depth  = depth;
    o.sphere.color  = color;
    return o;
  endfunction

  function automatic rtx_scene_pkg::scene_obj_u make_rect(
      input rtx_scene_pkg::coord_t x0, input rtx_scene_pkg::coord_t y0,
      input rtx_scene_pkg::coord_t x1, input rtx_scene_pkg::coord_t y1,
      input rtx_scene_pkg::coord_t depth, input logic [15:0] color);
    rtx_scene_pkg::scene_obj_u o;
    o            = '0;
    o.rect.kind  = rtx_scene_pkg::OBJ_RECT;
    o.rect.x0    = x0;
    o.rect.y0    = y0;
    o.rect.x1    = x1;
    o.rect.y1    = y1;
    o.rect.depth = depth;
    o.rect.color = color;
    return o;
  endfunction

  function automatic rtx_scene_pkg::scene_obj_u random_object();
    logic [31:0] pick;
    int          x;
    int          y;
    int          size;
    logic [7:0]  depth;
    logic [15:0] color;
    pick  = $random(seed);
    x     = $unsigned($random(seed)) % W;
    y     = $unsigned($random(seed)) % H;
    size  = $unsigned($random(seed)) % 4;
    depth = $random(seed);
    color = $random(seed);
    if (pick[0]) begin
      return make_rect(x, y, x + size, y + (size % 3), depth, color);
    end
    return make_sphere(x, y, size, depth, color);
  endfunction

  // Nearest hit wins, ties keep the lower index
  function automatic logic [15:0] expected_color(input int h, input int v);
    rtx_scene_pkg::scene_obj_u o;
    logic [15:0] color;
    int          best;
    int          dx;
    int          dy;
    int          d;
    logic        is_hit;
    color = `RTX_BG_COLOR;
    best  = 256;
    for (int i = 0; i < model_count; i++) begin
      o = model_obj[i];
      if (o.rect.kind == rtx_scene_pkg::OBJ_RECT) begin
        is_hit = (h >= int'(o.rect.x0)) && (h <= int'(o.rect.x1)) &&
                 (v >= int'(o.rect.y0)) && (v <= int'(o.rect.y1));
        d      = o.rect.depth;
      end else begin
        dx     = h - int'(o.sphere.cx);
        dy     = v - int'(o.sphere.cy);
        is_hit = (dx * dx + dy * dy) <= int'(o.sphere.radius) * int'(o.sphere.radius);
        d      = o.sphere.depth;
      end
      if (is_hit && d < best) begin
        best  = d;
        color = (o.rect.kind == rtx_scene_pkg::OBJ_RECT) ? o.rect.color : o.sphere.color;
      end
    end
    return color;
  endfunction

  task automatic render_frame(input string name, input bit restart);
    int pix;
    int exp_h;
    int exp_v;
    int stray;
    bit done;
    pix   = 0;
    exp_h = 0;
    exp_v = 0;
    stray = 0;
    done  = 1'b0;
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (ray_done) begin
        check_value($sformatf("%s pixel %0d h", name, pix), exp_h, pixel_h);
        check_value($sformatf("%s pixel %0d v", name, pix), exp_v, pixel_v);
        check_value($sformatf("%s pixel %0d colour", name, pix),
                    expected_color(exp_h, exp_v), rtx_pixel);
        check_value($sformatf("%s pixel %0d frame_done", name, pix),
                    pix == W * H - 1, frame_done);
        pix++;
        done = frame_done || (pix == W * H);
        exp_h++;
        if (exp_h == W) begin
          exp_h = 0;
          exp_v++;
        end
        // Start pulse in mid frame should be ignored
        if (restart && pix == 2) begin
          @(posedge clk);
          #1 start = 1'b1;
          @(posedge clk);
          #1 start = 1'b0;
        end
      end
    end
    check_value({name, " pixel count"}, W * H, pix);
    repeat (2 * (DEPTH + 4)) begin
      @(negedge clk);
      if (ray_done) begin
        stray++;
      end
    end
    check_value({name, " pixels after frame_done"}, 0, stray);
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed        = 32'h9a3d;
    value_errs  = 0;
    proto_errs  = 0;
    model_count = 0;
    rst_n       = 1'b0;
    start       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = 4'hf;
    wvalid      = 1'b0;
    bready      = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_value("reset ray_done", 0, ray_done);
    check_value("reset frame_done", 0, frame_done);
    check_value("reset awready", 0, awready);
    check_value("reset wready", 0, wready);
    check_value("reset bvalid", 0, bvalid);
    render_frame("empty scene", 1'b0);

    // Sphere behind a nearer rectangle, plus rejected writes
    queue_object(0, make_sphere(3, 2, 2, 80, 16'hf800));
    queue_object(1, make_rect(2, 1, 6, 4, 40, 16'h07e0));
    queue_write(8 * DEPTH, 32'h1234_5678, axi_lite_pkg::RESP_SLVERR);
    queue_write(8 * DEPTH + 4, 32'h9abc_def0, axi_lite_pkg::RESP_SLVERR);
    queue_count(2);
    queue_count(DEPTH + 1);
    run_writes();
    render_frame("overlap", 1'b0);

    // Same depth on both
    queue_object(0, make_rect(1, 1, 4, 3, 50, 16'h001f));
    queue_object(1, make_sphere(4, 3, 2, 50, 16'hffe0));
    run_writes();
    render_frame("equal depth", 1'b0);

    queue_count(1);
    run_writes();
    render_frame("count one", 1'b1);

    for (int i = 0; i < DEPTH; i++) begin
      queue_object(i, random_object());
    end
    queue_count(DEPTH);
    run_writes();
    render_frame("random scene", 1'b0);

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- verilog/rtx_top.sv
`timescale 1ns/1ps
`include "rtx_params.svh"

module rtx_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  axi_lite_pkg::axi_addr_t awaddr,
  input  logic                   awvalid,
  input  axi_lite_pkg::axi_data_t wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  input  logic                   bready,
  output logic                   awready,
  output logic                   wready,
  output axi_lite_pkg::axi_resp_e bresp,
  output logic                   bvalid,
  output logic [15:0]            rtx_pixel,
  output rtx_scene_pkg::coord_t  pixel_h,
  output rtx_scene_pkg::coord_t  pixel_v,
  output logic                   ray_done,
  output logic                   frame_done
);

  logic                       frame_start;
  logic                       next_pixel;
  logic                       last_pixel;
  logic [2:0]                 obj_idx;
  logic [3:0]                 obj_count;
  rtx_scene_pkg::scene_obj_u  obj;
  logic                       test_valid;
  logic                       hit_valid;
  logic                       hit;
  rtx_scene_pkg::coord_t      hit_depth;
  logic [15:0]                hit_color;

  ray_control u_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .last_pixel (last_pixel),
    .obj_count  (obj_count),
    .hit        (hit),
    .hit_valid  (hit_valid),
    .hit_depth  (hit_depth),
    .hit_color  (hit_color),
    .frame_start(frame_start),
    .next_pixel (next_pixel),
    .obj_idx    (obj_idx),
    .test_valid (test_valid),
    .ray_done   (ray_done),
    .frame_done (frame_done),
    .rtx_pixel  (rtx_pixel)
  );

  ray_caster #(
    .WIDTH (`RTX_WIDTH),
    .HEIGHT(`RTX_HEIGHT)
  ) u_caster (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_start(frame_start),
    .next_pixel (next_pixel),
    .pixel_h    (pixel_h),
    .pixel_v    (pixel_v),
    .last_pixel (last_pixel)
  );

  scene_buffer #(
    .DEPTH(`RTX_SCENE_DEPTH)
  ) u_scene (
    .clk      (clk),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .bready   (bready),
    .obj_idx  (obj_idx),
    .awready  (awready),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .obj      (obj),
    .obj_count(obj_count)
  );

  hit_test u_hit (
    .clk       (clk),
    .rst_n     (rst_n),
    .test_valid(test_valid),
    .obj       (obj),
    .ray_h     (pixel_h),
    .ray_v     (pixel_v),
    .hit_valid (hit_valid),
    .hit       (hit),
    .hit_depth (hit_depth),
    .hit_color (hit_color)
  );

endmodule

//--- verilog/ray_control.sv
`timescale 1ns/1ps
`include "rtx_params.svh"

module ray_control (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  last_pixel,
  input  logic [3:0]            obj_count,
  input  logic                  hit,
  input  logic                  hit_valid,
  input  rtx_scene_pkg::coord_t hit_depth,
  input  logic [15:0]           hit_color,
  output logic                  frame_start,
  output logic                  next_pixel,
  output logic [2:0]            obj_idx,
  output logic                  test_valid,
  output logic                  ray_done,
  output logic                  frame_done,
  output logic [15:0]           rtx_pixel
);

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    FINISH
  } state_e;

  state_e                state;
  logic [3:0]            cnt;
  logic [3:0]            last_cnt;
  logic                  pixel_end;
  logic                  take_hit;
  logic                  best_hit;
  rtx_scene_pkg::coord_t best_depth;
  logic [15:0]           best_color;

  // Two extra cycles drain the fetch and test stages
  assign last_cnt    = obj_count + 4'd2;
  assign pixel_end   = (state == FETCH) && (cnt == last_cnt);
  assign obj_idx     = cnt[2:0];
  assign frame_start = (state == IDLE) && start;
  assign next_pixel  = (state == FINISH);

  // Strictly nearer only, so the lower index keeps a tie
  assign take_hit = hit_valid && hit && (!best_hit || hit_depth < best_depth);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      cnt        <= '0;
      test_valid <= 1'b0;
      best_hit   <= 1'b0;
      ray_done   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      // Object fetched this cycle reaches hit_test next cycle
      test_valid <= (state == FETCH) && (cnt < obj_count);
      ray_done   <= pixel_end;
      frame_done <= pixel_end && last_pixel;
      case (state)
        IDLE: begin
          if (start) begin
            state    <= FETCH;
            cnt      <= '0;
            best_hit <= 1'b0;
          end
        end
        FETCH: begin
          if (take_hit) begin
            best_hit <= 1'b1;
          end
          if (pixel_end) begin
            state <= FINISH;
          end else begin
            cnt <= cnt + 4'd1;
          end
        end
        FINISH: begin
          cnt      <= '0;
          best_hit <= 1'b0;
          state    <= last_pixel ? IDLE : FETCH;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_hit) begin
      best_depth <= hit_depth;
      best_color <= hit_color;
    end
    if (pixel_end) begin
      rtx_pixel <= best_hit ? best_color : `RTX_BG_COLOR;
    end
  end

  a_done_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ray_done |-> state != IDLE);

  a_frame_with_ray: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> ray_done);

endmodule

//--- scene/scene_buffer.sv
`timescale 1ns/1ps
`include "rtx_params.svh"

module scene_buffer #(
  parameter int DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  axi_lite_pkg::axi_addr_t       awaddr,
  input  logic                          awvalid,
  input  axi_lite_pkg::axi_data_t       wdata,
  input  logic [3:0]                    wstrb,
  input  logic                          wvalid,
  input  logic                          bready,
  input  logic [$clog2(DEPTH)-1:0]      obj_idx,
  output logic                          awready,
  output logic                          wready,
  output axi_lite_pkg::axi_resp_e       bresp,
  output logic                          bvalid,
  output rtx_scene_pkg::scene_obj_u     obj,
  output logic [$clog2(DEPTH+1)-1:0]    obj_count
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  rtx_scene_pkg::scene_obj_u mem [DEPTH];

  logic       accept;
  logic       is_count;
  logic [8:0] slot;
  logic       slot_ok;
  logic       count_ok;

  // Address and data are taken together, never while a response waits
  assign accept  = awvalid && wvalid && !bvalid;
  assign awready = accept;
  assign wready  = accept;

  assign is_count = (awaddr == `RTX_COUNT_ADDR);
  assign slot     = awaddr[11:3];
  assign slot_ok  = !is_count && (slot < DEPTH);
  assign count_ok = is_count && (wdata <= DEPTH);

  // Bit 2 picks the half of the 64-bit object
  always_ff @(posedge clk) begin
    if (accept && slot_ok) begin
      if (awaddr[2]) begin
        mem[slot[IDX_W-1:0]][63:32] <= wdata;
      end else begin
        mem[slot[IDX_W-1:0]][31:0] <= wdata;
      end
    end
    obj <= mem[obj_idx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid    <= 1'b0;
      bresp     <= axi_lite_pkg::RESP_OKAY;
      obj_count <= '0;
    end else begin
      if (accept) begin
        bvalid <= 1'b1;
        bresp  <= (slot_ok || count_ok) ? axi_lite_pkg::RESP_OKAY
                                        : axi_lite_pkg::RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (accept && count_ok) begin
        obj_count <= wdata[CNT_W-1:0];
      end
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

//--- verilog/hit_test.sv
`timescale 1ns/1ps

module hit_test (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      test_valid,
  input  rtx_scene_pkg::scene_obj_u obj,
  input  rtx_scene_pkg::coord_t     ray_h,
  input  rtx_scene_pkg::coord_t     ray_v,
  output logic                      hit_valid,
  output logic                      hit,
  output rtx_scene_pkg::coord_t     hit_depth,
  output logic [15:0]               hit_color
);

  logic               is_rect;
  logic signed [16:0] dx;
  logic signed [16:0] dy;
  logic signed [16:0] dx2;
  logic signed [16:0] dy2;
  logic [17:0]        dist2;
  logic [15:0]        r2;
  logic               sphere_hit;
  logic               rect_hit;

  assign is_rect = (obj.sphere.kind == rtx_scene_pkg::OBJ_RECT);

  // Sphere seen end-on is a disc
  assign dx  = $signed({9'd0, ray_h}) - $signed({9'd0, obj.sphere.cx});
  assign dy  = $signed({9'd0, ray_v}) - $signed({9'd0, obj.sphere.cy});
  assign dx2 = dx * dx;
  assign dy2 = dy * dy;
  // One extra bit so corner pixels far from the centre cannot wrap
  assign dist2      = {1'b0, dx2} + {1'b0, dy2};
  assign r2         = obj.sphere.radius * obj.sphere.radius;
  assign sphere_hit = (dist2 <= {2'b00, r2});

  assign rect_hit = (ray_h >= obj.rect.x0) && (ray_h <= obj.rect.x1) &&
                    (ray_v >= obj.rect.y0) && (ray_v <= obj.rect.y1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= test_valid;
    end
  end

  always_ff @(posedge clk) begin
    hit       <= is_rect ? rect_hit : sphere_hit;
    hit_depth <= is_rect ? obj.rect.depth : obj.sphere.depth;
    hit_color <= is_rect ? obj.rect.color : obj.sphere.color;
  end

endmodule

//--- verilog/ray_caster.sv
`timescale 1ns/1ps

module ray_caster #(
  parameter int WIDTH  = 8,
  parameter int HEIGHT = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_start,
  input  logic                  next_pixel,
  output rtx_scene_pkg::coord_t pixel_h,
  output rtx_scene_pkg::coord_t pixel_v,
  output logic                  last_pixel
);

  logic h_end;
  logic v_end;

  assign h_end      = (pixel_h == rtx_scene_pkg::coord_t'(WIDTH - 1));
  assign v_end      = (pixel_v == rtx_scene_pkg::coord_t'(HEIGHT - 1));
  assign last_pixel = h_end && v_end;

  // Raster order, h fastest
  always_ff @(posedge clk) begin
    if (!rst_n || frame_start) begin
      pixel_h <= '0;
      pixel_v <= '0;
    end else if (next_pixel) begin
      if (h_end) begin
        pixel_h <= '0;
        pixel_v <= v_end ? '0 : pixel_v + 8'd1;
      end else begin
        pixel_h <= pixel_h + 8'd1;
      end
    end
  end

endmodule

//--- common/rtx_scene_pkg.sv
package rtx_scene_pkg;

  // Pixel or object coordinate
  typedef logic [7:0] coord_t;

  typedef enum logic {
    OBJ_SPHERE = 1'b0,
    OBJ_RECT   = 1'b1
  } obj_kind_e;

  // Disc centred on (cx, cy)
  typedef struct packed {
    obj_kind_e   kind;
    logic [6:0]  pad_hi;
    coord_t      cx;
    coord_t      cy;
    coord_t      radius;
    coord_t      depth;
    logic [15:0] color;
    logic [7:0]  pad_lo;
  } sphere_t;

  // Axis-aligned box, corners inclusive
  typedef struct packed {
    obj_kind_e   kind;
    coord_t      x0;
    coord_t      y0;
    coord_t      x1;
    coord_t      y1;
    coord_t      depth;
    logic [15:0] color;
    logic [6:0]  pad_lo;
  } rect_t;

  // Kind bit is bit 63 in both views
  typedef union packed {
    sphere_t sphere;
    rect_t   rect;
  } scene_obj_u;

endpackage

//--- common/axi_lite_pkg.sv
package axi_lite_pkg;

  typedef logic [11:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  // Only the two responses this slave can give
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

//--- common/rtx_params.svh
`ifndef RTX_PARAMS_SVH
`define RTX_PARAMS_SVH

// Frame size in pixels, up to 256 x 256
`define RTX_WIDTH 8
`define RTX_HEIGHT 6

// Number of object slots in the scene buffer
`define RTX_SCENE_DEPTH 8

// RGB565 colour for pixels that hit nothing
`define RTX_BG_COLOR 16'h1082

// Byte address of the object count register
`define RTX_COUNT_ADDR 12'h100

`endif
